// ==== Makefile ====
# Verilator build and run for the memory puzzle testbench.

VERILATOR ?= verilator
TOP       ?= tb_memory_game
DUT_TOP   ?= memory_game
FILELIST  ?= memory_game.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== memory_game.f ====
rtl/mem_pkg.sv
rtl/mem_puzzle_gen.sv
rtl/mem_answer_unit.sv
rtl/mem_game_ctrl.sv
rtl/memory_game.sv
verification/mem_checker.sv
verification/tb_memory_game.sv

// ==== rtl/mem_answer_unit.sv ====
/*
    Memory puzzle answer unit.
    Keeps the press history and applies the stage rules to find the required button.
*/
`timescale 1ns/1ps

module mem_answer_unit import mem_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  stage_t     stage,
    input  digit_t     cur_display,
    input  label_row_t cur_labels,
    input  logic       record,
    input  digit_t     rec_pos,
    input  logic       hist_clear,
    output digit_t     need_pos
);

    history_t hist;

    // position on the current row that carries the given label.
    function automatic digit_t find_label(input label_row_t row, input digit_t lbl);
        digit_t pos;
        pos = '0;
        for (int i = 0; i < NUM_POS; i++) begin
            if (row[i] == lbl) begin
                pos = digit_t'(i);
            end
        end
        return pos;
    endfunction

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            hist <= '0;
        end else if (hist_clear) begin
            hist <= '0;
        end else if (record) begin
            hist.pos[stage]   <= rec_pos;
            hist.label[stage] <= cur_labels[rec_pos];
        end
    end

    // display code d means digit d+1, label code 3 is label 4.
    always_comb begin
        need_pos = '0;
        case (stage)
            3'd0: begin
                case (cur_display)
                    2'd0:    need_pos = 2'd1;
                    2'd1:    need_pos = 2'd1;
                    2'd2:    need_pos = 2'd2;
                    default: need_pos = 2'd3;
                endcase
            end
            3'd1: begin
                case (cur_display)
                    2'd0:    need_pos = find_label(cur_labels, 2'd3);
                    2'd1:    need_pos = hist.pos[0];
                    2'd2:    need_pos = 2'd0;
                    default: need_pos = hist.pos[0];
                endcase
            end
            3'd2: begin
                case (cur_display)
                    2'd0:    need_pos = find_label(cur_labels, hist.label[1]);
                    2'd1:    need_pos = find_label(cur_labels, hist.label[0]);
                    2'd2:    need_pos = 2'd2;
                    default: need_pos = find_label(cur_labels, 2'd3);
                endcase
            end
            3'd3: begin
                case (cur_display)
                    2'd0:    need_pos = hist.pos[0];
                    2'd1:    need_pos = 2'd0;
                    2'd2:    need_pos = hist.pos[1];
                    default: need_pos = hist.pos[1];
                endcase
            end
            3'd4: begin
                case (cur_display)
                    2'd0:    need_pos = find_label(cur_labels, hist.label[0]);
                    2'd1:    need_pos = find_label(cur_labels, hist.label[1]);
                    2'd2:    need_pos = find_label(cur_labels, hist.label[3]);
                    default: need_pos = find_label(cur_labels, hist.label[2]);
                endcase
            end
            default: need_pos = '0;
        endcase
    end

endmodule

// ==== rtl/mem_game_ctrl.sv ====
/*
    Memory puzzle game controller.
    Game FSM, stage and strike counters, puzzle snapshot and press judgement.
*/
`timescale 1ns/1ps

module mem_game_ctrl import mem_pkg::*; (
    input  logic        clk,
    input  logic        nrst,
    input  logic        start,
    input  press_t      press,
    input  puzzle_t     cand_puzzle,
    input  digit_t      need_pos,
    output stage_t      stage,
    output digit_t      cur_display,
    output label_row_t  cur_labels,
    output logic        record,
    output digit_t      rec_pos,
    output logic        hist_clear,
    output logic [1:0]  strikes,
    output game_state_e state,
    output logic        correct,
    output logic        strike
);

    puzzle_t snap;
    logic    start_ok;
    logic    press_ok;
    logic    hit;
    logic    miss;
    logic    new_round;
    logic    last_stage;
    logic    last_strike;

    // start is ignored while a game is running.
    assign start_ok    = start && (state != ST_PLAY);
    assign press_ok    = press.valid && (state == ST_PLAY);
    assign hit         = (press.pos == need_pos);
    assign miss        = press_ok && !hit;
    assign last_stage  = (stage == stage_t'(NUM_STAGES - 1));
    assign last_strike = (strikes == 2'(MAX_STRIKES - 1));

    // fresh puzzle and empty history on start and after every strike.
    assign new_round  = start_ok || miss;
    assign hist_clear = new_round;

    assign record  = press_ok && hit;
    assign rec_pos = press.pos;

    assign cur_display = snap.display[stage];
    assign cur_labels  = snap.labels[stage];

    always_ff @(posedge clk) begin
        if (new_round) begin
            snap <= cand_puzzle;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state   <= ST_IDLE;
            stage   <= '0;
            strikes <= '0;
            correct <= 1'b0;
            strike  <= 1'b0;
        end else begin
            correct <= 1'b0;
            strike  <= 1'b0;
            case (state)
                ST_PLAY: begin
                    if (press_ok && hit) begin
                        correct <= 1'b1;
                        if (last_stage) begin
                            state <= ST_SOLVED;    // stage stays at the last one.
                        end else begin
                            stage <= stage + 3'd1;
                        end
                    end else if (miss) begin
                        strike  <= 1'b1;
                        strikes <= strikes + 2'd1;
                        stage   <= '0;
                        if (last_strike) begin
                            state <= ST_LOST;
                        end
                    end
                end
                default: begin
                    // idle, solved and lost all wait for start.
                    if (start_ok) begin
                        state   <= ST_PLAY;
                        stage   <= '0;
                        strikes <= '0;
                    end
                end
            endcase
        end
    end

endmodule

// ==== rtl/mem_pkg.sv ====
/*
    Memory puzzle shared definitions.
    Stage, digit, label row, puzzle and press types plus the game states.
*/
package mem_pkg;

    localparam int NUM_STAGES  = 5;
    localparam int NUM_POS     = 4;
    localparam int LFSR_WIDTH  = 12;
    localparam int MAX_STRIKES = 3;

    // digits, labels and positions, code 0..3 stands for 1..4.
    typedef logic [1:0] digit_t;

    typedef logic [2:0] stage_t;

    // entry i is the label on button position i.
    typedef digit_t [NUM_POS-1:0] label_row_t;

    typedef struct packed {
        digit_t     [NUM_STAGES-1:0] display;
        label_row_t [NUM_STAGES-1:0] labels;
    } puzzle_t;

    typedef struct packed {
        logic   valid;     // single-cycle strobe.
        digit_t pos;
    } press_t;

    // what was pressed at each stage so far.
    typedef struct packed {
        digit_t [NUM_STAGES-1:0] pos;
        digit_t [NUM_STAGES-1:0] label;
    } history_t;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_PLAY   = 2'd1,
        ST_SOLVED = 2'd2,
        ST_LOST   = 2'd3
    } game_state_e;

endpackage

// ==== rtl/mem_puzzle_gen.sv ====
/*
    Memory puzzle generator.
    Free-running LFSR for the display digits and five label rows reshuffled every clock.
*/
`timescale 1ns/1ps

module mem_puzzle_gen import mem_pkg::*; (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic [LFSR_WIDTH-1:0] random_seed,
    output puzzle_t               cand_puzzle
);

    logic [LFSR_WIDTH-1:0]        lfsr;
    label_row_t [NUM_STAGES-1:0]  rows;
    label_row_t [NUM_STAGES-1:0]  nxt_rows;

    // source position for each output position, per row and select.
    function automatic label_row_t perm_src(input logic [2:0] row, input logic [1:0] sel);
        label_row_t src;
        case ({row, sel})
            {3'd0, 2'd0}: src = {2'd1, 2'd2, 2'd3, 2'd0};
            {3'd0, 2'd1}: src = {2'd3, 2'd0, 2'd1, 2'd2};
            {3'd0, 2'd2}: src = {2'd1, 2'd0, 2'd3, 2'd2};
            {3'd0, 2'd3}: src = {2'd2, 2'd3, 2'd0, 2'd1};
            {3'd1, 2'd0}: src = {2'd2, 2'd3, 2'd1, 2'd0};
            {3'd1, 2'd1}: src = {2'd1, 2'd2, 2'd0, 2'd3};
            {3'd1, 2'd2}: src = {2'd3, 2'd0, 2'd1, 2'd2};
            {3'd1, 2'd3}: src = {2'd2, 2'd0, 2'd3, 2'd1};
            {3'd2, 2'd0}: src = {2'd3, 2'd2, 2'd1, 2'd0};
            {3'd2, 2'd1}: src = {2'd2, 2'd1, 2'd0, 2'd3};
            {3'd2, 2'd2}: src = {2'd1, 2'd2, 2'd3, 2'd0};
            {3'd2, 2'd3}: src = {2'd1, 2'd3, 2'd0, 2'd2};
            {3'd3, 2'd0}: src = {2'd1, 2'd0, 2'd3, 2'd2};
            {3'd3, 2'd1}: src = {2'd2, 2'd0, 2'd1, 2'd3};
            {3'd3, 2'd2}: src = {2'd3, 2'd1, 2'd0, 2'd2};
            {3'd3, 2'd3}: src = {2'd0, 2'd3, 2'd2, 2'd1};
            {3'd4, 2'd0}: src = {2'd0, 2'd2, 2'd3, 2'd1};
            {3'd4, 2'd1}: src = {2'd0, 2'd3, 2'd1, 2'd2};
            {3'd4, 2'd2}: src = {2'd1, 2'd2, 2'd3, 2'd0};
            {3'd4, 2'd3}: src = {2'd2, 2'd0, 2'd3, 2'd1};
            default:      src = {2'd3, 2'd2, 2'd1, 2'd0};
        endcase
        return src;
    endfunction

    always_comb begin
        label_row_t src;
        for (int r = 0; r < NUM_STAGES; r++) begin
            src = perm_src(3'(r), lfsr[1:0]);
            for (int p = 0; p < NUM_POS; p++) begin
                nxt_rows[r][p] = rows[r][src[p]];
            end
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            lfsr <= random_seed;
            for (int r = 0; r < NUM_STAGES; r++) begin
                rows[r] <= {2'd3, 2'd2, 2'd1, 2'd0};    // position i carries label i.
            end
        end else begin
            lfsr <= {lfsr[LFSR_WIDTH-2:0],
                     lfsr[LFSR_WIDTH-1] ~^ lfsr[6] ~^ lfsr[4] ~^ lfsr[1]};
            rows <= nxt_rows;
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_STAGES; k++) begin
            cand_puzzle.display[k] = lfsr[2*k +: 2];    // top two bits only feed back.
        end
        cand_puzzle.labels = rows;
    end

endmodule

// ==== rtl/memory_game.sv ====
/*
    Memory puzzle top level.
    Connects the puzzle generator, the game controller and the answer unit.
*/
`timescale 1ns/1ps

module memory_game import mem_pkg::*; (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic [LFSR_WIDTH-1:0] random_seed,
    input  logic                  start,
    input  press_t                press,
    output digit_t                display_num,
    output label_row_t            labels,
    output stage_t                stage,
    output logic [1:0]            strikes,
    output game_state_e           state,
    output logic                  correct,
    output logic                  strike
);

    puzzle_t cand_puzzle;
    digit_t  need_pos;
    logic    record;
    digit_t  rec_pos;
    logic    hist_clear;

    mem_puzzle_gen mem_puzzle_gen_i (
        .clk         (clk),
        .nrst        (nrst),
        .random_seed (random_seed),
        .cand_puzzle (cand_puzzle)
    );

    mem_game_ctrl mem_game_ctrl_i (
        .clk         (clk),
        .nrst        (nrst),
        .start       (start),
        .press       (press),
        .cand_puzzle (cand_puzzle),
        .need_pos    (need_pos),
        .stage       (stage),
        .cur_display (display_num),
        .cur_labels  (labels),
        .record      (record),
        .rec_pos     (rec_pos),
        .hist_clear  (hist_clear),
        .strikes     (strikes),
        .state       (state),
        .correct     (correct),
        .strike      (strike)
    );

    mem_answer_unit mem_answer_unit_i (
        .clk         (clk),
        .nrst        (nrst),
        .stage       (stage),
        .cur_display (display_num),
        .cur_labels  (labels),
        .record      (record),
        .rec_pos     (rec_pos),
        .hist_clear  (hist_clear),
        .need_pos    (need_pos)
    );

endmodule

// ==== verification/mem_checker.sv ====
/*
    Memory puzzle checker.
    Models the stage rules, strikes and game state, and compares them with the DUT.
*/
`timescale 1ns/1ps

module mem_checker import mem_pkg::*; (
    input  logic        clk,
    input  logic        nrst,
    input  logic        start,
    input  press_t      press,
    input  digit_t      display_num,
    input  label_row_t  labels,
    input  stage_t      stage,
    input  logic [1:0]  strikes,
    input  game_state_e state,
    input  logic        correct,
    input  logic        strike,
    output digit_t      exp_pos,
    output int          err_count,
    output logic        all_covered
);

    game_state_e m_state;
    stage_t      m_stage;
    logic [1:0]  m_strikes;
    logic        m_correct;
    logic        m_strike;
    digit_t      m_pos [NUM_STAGES];
    digit_t      m_lbl [NUM_STAGES];
    logic        quiet;
    digit_t      last_disp;
    label_row_t  last_lbls;
    logic [3:0]  lbl_mask;
    bit          seen [NUM_STAGES][NUM_POS];
    int          errs = 0;

    function automatic digit_t pos_of(input label_row_t row, input digit_t lbl);
        digit_t res;
        res = '0;
        for (int i = NUM_POS - 1; i >= 0; i--) begin
            if (row[i] == lbl) begin
                res = 2'(i);
            end
        end
        return res;
    endfunction

    // display d shows the digit d+1, label code 3 is label 4.
    function automatic digit_t rule_pos(input stage_t stg, input digit_t disp,
                                        input label_row_t row,
                                        input digit_t p0, input digit_t p1,
                                        input digit_t l0, input digit_t l1,
                                        input digit_t l2, input digit_t l3);
        int dnum;
        dnum = int'(disp) + 1;
        case (stg)
            3'd0:    return (dnum <= 2) ? 2'd1 : 2'(dnum - 1);
            3'd1:    return (dnum == 1) ? pos_of(row, 2'd3) : ((dnum == 3) ? 2'd0 : p0);
            3'd2: begin
                case (dnum)
                    1:       return pos_of(row, l1);
                    2:       return pos_of(row, l0);
                    3:       return 2'd2;
                    default: return pos_of(row, 2'd3);
                endcase
            end
            3'd3:    return (dnum == 1) ? p0 : ((dnum == 2) ? 2'd0 : p1);
            default: begin
                case (dnum)
                    1:       return pos_of(row, l0);
                    2:       return pos_of(row, l1);
                    3:       return pos_of(row, l3);
                    default: return pos_of(row, l2);
                endcase
            end
        endcase
    endfunction

    task automatic compare_value(input string name, input int got, input int exp);
        if (got != exp) begin
            errs++;
            $display("Error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_fault(input string msg);
        errs++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    assign exp_pos   = rule_pos(m_stage, display_num, labels, m_pos[0], m_pos[1],
                                m_lbl[0], m_lbl[1], m_lbl[2], m_lbl[3]);
    assign err_count = errs;

    always_comb begin
        lbl_mask = '0;
        for (int i = 0; i < NUM_POS; i++) begin
            lbl_mask[labels[i]] = 1'b1;
        end
    end

    always_comb begin
        all_covered = 1'b1;
        for (int s = 0; s < NUM_STAGES; s++) begin
            for (int d = 0; d < NUM_POS; d++) begin
                all_covered = all_covered && seen[s][d];
            end
        end
    end

    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            m_state   <= ST_IDLE;
            m_stage   <= '0;
            m_strikes <= '0;
            m_correct <= 1'b0;
            m_strike  <= 1'b0;
            quiet     <= 1'b0;
            for (int s = 0; s < NUM_STAGES; s++) begin
                m_pos[s] <= '0;
                m_lbl[s] <= '0;
            end
        end else begin
            compare_value("state", int'(state), int'(m_state));
            compare_value("stage", int'(stage), int'(m_stage));
            compare_value("strikes", int'(strikes), int'(m_strikes));
            compare_value("correct", int'(correct), int'(m_correct));
            compare_value("strike", int'(strike), int'(m_strike));
            if (m_state == ST_PLAY && lbl_mask != 4'hf) begin
                report_fault($sformatf("labels %h are not a permutation of 0 to 3", labels));
            end
            if (quiet && (display_num != last_disp || labels != last_lbls)) begin
                report_fault("display or labels changed without a press");
            end
            quiet     <= (m_state == ST_PLAY) && !press.valid;
            last_disp <= display_num;
            last_lbls <= labels;
            m_correct <= 1'b0;
            m_strike  <= 1'b0;
            if (m_state == ST_PLAY) begin
                if (press.valid) begin
                    seen[m_stage][display_num] <= 1'b1;
                    if (press.pos == exp_pos) begin
                        m_correct        <= 1'b1;
                        m_pos[m_stage]   <= press.pos;
                        m_lbl[m_stage]   <= labels[press.pos];
                        if (m_stage == stage_t'(NUM_STAGES - 1)) begin
                            m_state <= ST_SOLVED;
                        end else begin
                            m_stage <= m_stage + 3'd1;
                        end
                    end else begin
                        m_strike  <= 1'b1;
                        m_strikes <= m_strikes + 2'd1;
                        m_stage   <= '0;
                        for (int s = 0; s < NUM_STAGES; s++) begin
                            m_pos[s] <= '0;
                            m_lbl[s] <= '0;
                        end
                        if (m_strikes == 2'(MAX_STRIKES - 1)) begin
                            m_state <= ST_LOST;
                        end
                    end
                end
            end else if (start) begin
                m_state   <= ST_PLAY;
                m_stage   <= '0;
                m_strikes <= '0;
                for (int s = 0; s < NUM_STAGES; s++) begin
                    m_pos[s] <= '0;
                    m_lbl[s] <= '0;
                end
            end
        end
    end

endmodule

// ==== verification/tb_memory_game.sv ====
/*
    Memory puzzle testbench.
    Random player with a fixed seed against the DUT, outputs compared by mem_checker.
*/
`timescale 1ns/1ps

module tb_memory_game import mem_pkg::*; ();

    localparam int NUM_GAMES  = 40;
    localparam int MAX_PRESS  = 30;
    localparam int MAX_CYCLES = NUM_GAMES * MAX_PRESS * 5 + 1000;
    localparam int SEED       = 97230;

    logic                  clk = 1'b0;
    logic                  nrst;
    logic [LFSR_WIDTH-1:0] random_seed;
    logic                  start;
    press_t                press;
    digit_t                display_num;
    label_row_t            labels;
    stage_t                stage;
    logic [1:0]            strikes;
    game_state_e           state;
    logic                  correct;
    logic                  strike;
    digit_t                exp_pos;
    int                    err_count;
    logic                  all_covered;
    int                    cycles = 0;
    int                    n_tests = 0;
    int                    n_failed = 0;
    int                    errs_seen = 0;

    always #50 clk = ~clk;

    memory_game memory_game_i (
        .clk         (clk),
        .nrst        (nrst),
        .random_seed (random_seed),
        .start       (start),
        .press       (press),
        .display_num (display_num),
        .labels      (labels),
        .stage       (stage),
        .strikes     (strikes),
        .state       (state),
        .correct     (correct),
        .strike      (strike)
    );

    mem_checker checker_i (
        .clk         (clk),
        .nrst        (nrst),
        .start       (start),
        .press       (press),
        .display_num (display_num),
        .labels      (labels),
        .stage       (stage),
        .strikes     (strikes),
        .state       (state),
        .correct     (correct),
        .strike      (strike),
        .exp_pos     (exp_pos),
        .err_count   (err_count),
        .all_covered (all_covered)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles before all games ended", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    // each strobe lasts one cycle, outputs are read one cycle after it.
    task automatic pulse_start();
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
    endtask

    task automatic press_button(input digit_t pos);
        press.valid <= 1'b1;
        press.pos   <= pos;
        @(posedge clk);
        press.valid <= 1'b0;
        @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        int    errs;
        string verdict;
        @(negedge clk);
        errs      = err_count - errs_seen;
        errs_seen = err_count;
        n_tests++;
        if (errs != 0) begin
            n_failed++;
            verdict = "failed";
        end else begin
            verdict = "passed";
        end
        $display("%s: %s, %0d errors", name, verdict, errs);
        @(posedge clk);
    endtask

    task automatic play_game(input int game_no);
        int     presses;
        digit_t pos;
        string  result;
        presses = 0;
        pulse_start();
        while (state == ST_PLAY) begin
            if ($urandom_range(11) == 0) begin
                pulse_start();    // ignored during play.
            end
            repeat ($urandom_range(3)) @(posedge clk);
            pos = exp_pos;
            if ($urandom_range(5) == 0) begin
                pos = pos + 2'($urandom_range(3, 1));    // deliberate miss.
            end
            press_button(pos);
            presses++;
        end
        if (state == ST_SOLVED) begin
            result = "solved";
        end else begin
            result = "lost";
        end
        repeat (2) press_button(2'($urandom_range(3)));
        finish_test($sformatf("game %0d %s after %0d presses", game_no, result, presses));
    endtask

    initial begin
        void'($urandom(SEED));
        nrst        <= 1'b0;
        start       <= 1'b0;
        press       <= '0;
        random_seed <= 12'($urandom) & ~12'h001;    // all ones locks the lfsr.
        repeat (10) @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);
        repeat (4) press_button(2'($urandom_range(3)));
        finish_test("reset and idle");
        for (int g = 1; g <= NUM_GAMES; g++) begin
            play_game(g);
        end
        n_tests++;
        if (all_covered) begin
            $display("stage coverage: passed, every display value pressed at every stage");
        end else begin
            n_failed++;
            $display("stage coverage: failed, some display value was never pressed at a stage");
        end
        $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, err_count);
        if (n_failed == 0 && err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
